//--- src/sd_cmd_pkg.sv
`default_nettype none

package sd_cmd_pkg;

    // ======================================================================
    // Frame geometry on the CMD line
    // ======================================================================
    localparam int FRAME_BITS   = 48;
    // Start, direction, index and argument bits covered by the CRC
    localparam int PAYLOAD_BITS = 40;
    localparam int CRC_BITS     = 7;

    // Idle cycles after the stop bit before the card may drive the line
    localparam int TURNAROUND_CYCLES = 2;

    // Wide enough to count any bit position inside a frame
    localparam int CNT_BITS = $clog2(FRAME_BITS);

    // ======================================================================
    // Vector types
    // ======================================================================
    typedef logic [FRAME_BITS-1:0]   frame_t;
    typedef logic [PAYLOAD_BITS-1:0] payload_t;
    typedef logic [CRC_BITS-1:0]     crc7_t;
    typedef logic [0:0]              resp_type_t;

    // x^7 + x^3 + 1, the x^7 term is implied
    localparam crc7_t CRC7_POLY = 7'h09;

    // Response type codes
    localparam resp_type_t RESP_NONE = 1'b0;
    localparam resp_type_t RESP_48   = 1'b1;

endpackage

`default_nettype wire

//--- src/sd_crc7.sv
`timescale 1ns/100ps
`default_nettype none

module sd_crc7 (
    input  wire                clk_fast,
    input  wire                clr,
    input  wire                en,
    input  wire                din,
    output sd_cmd_pkg::crc7_t  crc
);
    import sd_cmd_pkg::*;

    logic  feedback;
    crc7_t crc_next;

    // Serial LFSR, MSB of the register is the oldest term
    assign feedback = din ^ crc[CRC_BITS-1];

    always_comb begin
        crc_next = {crc[CRC_BITS-2:0], 1'b0};
        if (feedback) begin
            crc_next = crc_next ^ CRC7_POLY;
        end
    end

    // Cleared at the start of every frame
    always_ff @(posedge clk_fast) begin
        if (clr) begin
            crc <= '0;
        end else if (en) begin
            crc <= crc_next;
        end
    end

endmodule

`default_nettype wire

//--- src/sd_cmd_tx.sv
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_tx (
    input  wire                   clk_fast,
    input  wire                   init_resetPulse,
    input  wire                   tx_start,
    input  sd_cmd_pkg::payload_t  tx_payload,
    output logic                  cmd_out,
    output logic                  cmd_oe,
    output logic                  tx_done
);
    import sd_cmd_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_PAYLOAD,
        TX_CRC,
        TX_STOP
    } tx_state_t;

    tx_state_t             state;
    logic [CNT_BITS-1:0]   bit_cnt;
    payload_t              shreg;
    crc7_t                 crc;
    logic                  load;
    logic [2:0]            crc_idx;

    assign load    = tx_start && (state == TX_IDLE);
    assign crc_idx = bit_cnt[2:0];

    // ======================================================================
    // Frame sequencing: 40 payload bits, 7 CRC bits, 1 stop bit
    // ======================================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            cmd_oe  <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (tx_start) begin
                        state   <= TX_PAYLOAD;
                        bit_cnt <= CNT_BITS'(PAYLOAD_BITS - 1);
                        cmd_oe  <= 1'b1;
                    end
                end
                TX_PAYLOAD: begin
                    if (bit_cnt == '0) begin
                        state   <= TX_CRC;
                        bit_cnt <= CNT_BITS'(CRC_BITS - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                TX_CRC: begin
                    if (bit_cnt == '0) begin
                        state <= TX_STOP;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                TX_STOP: begin
                    // Line released, done visible in the next cycle
                    state   <= TX_IDLE;
                    cmd_oe  <= 1'b0;
                    tx_done <= 1'b1;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Payload shifter, MSB leaves first
    always_ff @(posedge clk_fast) begin
        if (load) begin
            shreg <= tx_payload;
        end else if (state == TX_PAYLOAD) begin
            shreg <= {shreg[PAYLOAD_BITS-2:0], 1'b0};
        end
    end

    sd_crc7 crc_i (
        .clk_fast (clk_fast),
        .clr      (load),
        .en       (state == TX_PAYLOAD),
        .din      (shreg[PAYLOAD_BITS-1]),
        .crc      (crc)
    );

    // Line mux, idle level is high
    always_comb begin
        case (state)
            TX_PAYLOAD: cmd_out = shreg[PAYLOAD_BITS-1];
            TX_CRC:     cmd_out = crc[crc_idx];
            default:    cmd_out = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- src/sd_resp_rx.sv
`timescale 1ns/100ps
`default_nettype none

module sd_resp_rx (
    input  wire                 clk_fast,
    input  wire                 init_resetPulse,
    input  wire                 rx_arm,
    input  wire                 cmd_in,
    output logic                resp_done,
    output sd_cmd_pkg::frame_t  resp_data,
    output logic                resp_crc_err
);
    import sd_cmd_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_GUARD,
        RX_HUNT,
        RX_SHIFT
    } rx_state_t;

    rx_state_t              state;
    logic [CNT_BITS-1:0]    bit_cnt;
    // Holds bits 47..1, the end bit is taken straight from the line
    logic [FRAME_BITS-2:0]  shreg;
    crc7_t                  crc;
    logic                   start_seen;
    logic                   crc_en;

    assign start_seen = (state == RX_HUNT) && !cmd_in;

    // Only the first 40 bits of the response are covered by the CRC
    assign crc_en = start_seen ||
                    ((state == RX_SHIFT) && (bit_cnt >= CNT_BITS'(CRC_BITS + 1)));

    // ======================================================================
    // Guard, start-bit search and frame capture
    // ======================================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state        <= RX_IDLE;
            bit_cnt      <= '0;
            resp_done    <= 1'b0;
            resp_data    <= '0;
            resp_crc_err <= 1'b0;
        end else begin
            resp_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_arm) begin
                        state   <= RX_GUARD;
                        bit_cnt <= CNT_BITS'(TURNAROUND_CYCLES - 1);
                    end
                end
                RX_GUARD: begin
                    // Line may still float from our own driver here
                    if (bit_cnt == '0) begin
                        state <= RX_HUNT;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                RX_HUNT: begin
                    if (start_seen) begin
                        state   <= RX_SHIFT;
                        bit_cnt <= CNT_BITS'(FRAME_BITS - 2);
                    end
                end
                RX_SHIFT: begin
                    if (bit_cnt == '0) begin
                        // cmd_in is the end bit now
                        state        <= RX_IDLE;
                        resp_done    <= 1'b1;
                        resp_data    <= {shreg, cmd_in};
                        resp_crc_err <= (shreg[CRC_BITS-1:0] != crc) || !cmd_in;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Bits enter at the LSB end
    always_ff @(posedge clk_fast) begin
        if ((state == RX_HUNT) || (state == RX_SHIFT)) begin
            shreg <= {shreg[FRAME_BITS-3:0], cmd_in};
        end
    end

    sd_crc7 crc_i (
        .clk_fast (clk_fast),
        .clr      (state == RX_GUARD),
        .en       (crc_en),
        .din      (cmd_in),
        .crc      (crc)
    );

endmodule

`default_nettype wire

//--- src/sd_cmd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_ctrl (
    input  wire                     clk_fast,
    input  wire                     init_resetPulse,
    input  wire                     cmd_start,
    input  sd_cmd_pkg::payload_t    cmd_payload,
    input  sd_cmd_pkg::resp_type_t  cmd_resp_type,
    input  wire                     tx_done,
    input  wire                     resp_done,
    output logic                    cmd_busy,
    output logic                    cmd_done,
    output logic                    tx_start,
    output sd_cmd_pkg::payload_t    tx_payload,
    output logic                    rx_arm
);
    import sd_cmd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_RESP
    } ctrl_state_t;

    ctrl_state_t  state;
    resp_type_t   resp_type;
    logic         accept;

    // New requests only count while nothing is in flight
    assign accept   = cmd_start && (state == IDLE);
    assign cmd_busy = (state != IDLE);

    // Completion and receiver arming share the cycle of tx_done
    assign cmd_done = (state == SEND) && tx_done;
    assign rx_arm   = cmd_done && (resp_type == RESP_48);

    // ======================================================================
    // Transaction FSM
    // ======================================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state    <= IDLE;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state    <= SEND;
                        tx_start <= 1'b1;
                    end
                end
                SEND: begin
                    if (tx_done) begin
                        state <= (resp_type == RESP_48) ? WAIT_RESP : IDLE;
                    end
                end
                WAIT_RESP: begin
                    if (resp_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request held stable for the whole transaction
    always_ff @(posedge clk_fast) begin
        if (accept) begin
            tx_payload <= cmd_payload;
            resp_type  <= cmd_resp_type;
        end
    end

endmodule

`default_nettype wire

//--- src/sd_cmd_top.sv
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_top (
    input  wire                     clk_fast,
    input  wire                     init_resetPulse,
    input  wire                     cmd_start,
    input  sd_cmd_pkg::payload_t    cmd_payload,
    input  sd_cmd_pkg::resp_type_t  cmd_resp_type,
    input  wire                     cmd_in,
    output logic                    cmd_busy,
    output logic                    cmd_done,
    output logic                    cmd_out,
    output logic                    cmd_oe,
    output logic                    resp_done,
    output sd_cmd_pkg::frame_t      resp_data,
    output logic                    resp_crc_err
);
    import sd_cmd_pkg::*;

    logic      tx_start;
    payload_t  tx_payload;
    logic      tx_done;
    logic      rx_arm;

    sd_cmd_ctrl ctrl_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_start       (cmd_start),
        .cmd_payload     (cmd_payload),
        .cmd_resp_type   (cmd_resp_type),
        .tx_done         (tx_done),
        .resp_done       (resp_done),
        .cmd_busy        (cmd_busy),
        .cmd_done        (cmd_done),
        .tx_start        (tx_start),
        .tx_payload      (tx_payload),
        .rx_arm          (rx_arm)
    );

    sd_cmd_tx tx_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .tx_start        (tx_start),
        .tx_payload      (tx_payload),
        .cmd_out         (cmd_out),
        .cmd_oe          (cmd_oe),
        .tx_done         (tx_done)
    );

    sd_resp_rx rx_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .rx_arm          (rx_arm),
        .cmd_in          (cmd_in),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err)
    );

endmodule

`default_nettype wire

//--- verif/sd_cmd_sva.sv
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_sva (
    input wire clk_fast,
    input wire init_resetPulse,
    input wire cmd_busy,
    input wire cmd_done,
    input wire cmd_oe,
    input wire resp_done
);
    int fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    // Completion is a single-cycle pulse
    a_done_pulse: assert property (
        @(posedge clk_fast) disable iff (init_resetPulse) cmd_done |=> !cmd_done
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("cmd_done stayed high for two cycles");
    end

    a_no_frame_at_resp: assert property (
        @(posedge clk_fast) disable iff (init_resetPulse) resp_done |-> !$rose(cmd_oe)
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("cmd_oe rose while resp_done was high");
    end

    // A response only closes an open transaction
    a_resp_in_busy: assert property (
        @(posedge clk_fast) disable iff (init_resetPulse) resp_done |-> cmd_busy
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("resp_done pulsed while cmd_busy was low");
    end

endmodule

`default_nettype wire

//--- verif/sd_cmd_checker.sv
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_checker (
    input  wire                     clk_fast,
    input  wire                     init_resetPulse,
    input  wire                     cmd_start,
    input  wire                     cmd_busy,
    input  wire                     cmd_done,
    input  wire                     cmd_out,
    input  wire                     cmd_oe,
    input  wire                     resp_done,
    input  sd_cmd_pkg::frame_t      resp_data,
    input  wire                     resp_crc_err,
    input  sd_cmd_pkg::resp_type_t  exp_resp_type,
    input  sd_cmd_pkg::frame_t      exp_frame,
    input  sd_cmd_pkg::frame_t      exp_resp,
    input  wire                     exp_err,
    output int                      value_errors,
    output int                      protocol_errors
);
    import sd_cmd_pkg::*;

    logic        was_reset;
    logic        active;
    logic        sent;
    logic        oe_q;
    logic        oe_fall;
    logic        release_due;
    int          age;
    int          nbits;
    frame_t      bits;
    resp_type_t  t_type;
    frame_t      t_frame;
    frame_t      t_resp;
    logic        t_err;

    task automatic flag_mismatch(input string name, input frame_t exp, input frame_t got);
        value_errors = value_errors + 1;
        $display("** Error %s: expected %h, got %h at %0t", name, exp, got, $time);
    endtask

    task automatic flag_protocol(input string what);
        protocol_errors = protocol_errors + 1;
        $display("Protocol failure at %0t: %s", $time, what);
    endtask

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        was_reset       = 1'b0;
        active          = 1'b0;
        oe_q            = 1'b0;
        release_due     = 1'b0;
    end

    // ======================================================================
    // Sampled on every rising edge, before the DUT registers update
    // ======================================================================
    always @(posedge clk_fast) begin
        if (init_resetPulse) begin
            was_reset   = 1'b1;
            active      = 1'b0;
            oe_q        = 1'b0;
            release_due = 1'b0;
        end else begin
            if (was_reset) begin
                if (cmd_oe !== 1'b0) begin
                    flag_mismatch("cmd_oe", '0, cmd_oe);
                end
                if (cmd_busy !== 1'b0) begin
                    flag_mismatch("cmd_busy", '0, cmd_busy);
                end
                if (cmd_done !== 1'b0) begin
                    flag_mismatch("cmd_done", '0, cmd_done);
                end
                if (resp_done !== 1'b0) begin
                    flag_mismatch("resp_done", '0, resp_done);
                end
                if (resp_crc_err !== 1'b0) begin
                    flag_mismatch("resp_crc_err", '0, resp_crc_err);
                end
                if (resp_data !== '0) begin
                    flag_mismatch("resp_data", '0, resp_data);
                end
                was_reset = 1'b0;
            end
            // Busy drops in the cycle after the closing pulse
            if (release_due && cmd_busy !== 1'b0) begin
                flag_mismatch("cmd_busy", '0, cmd_busy);
            end
            release_due = 1'b0;

            if (cmd_start && !cmd_busy) begin
                if (active) begin
                    flag_protocol("request accepted while a transaction was open");
                end
                active  = 1'b1;
                sent    = 1'b0;
                age     = 0;
                t_type  = exp_resp_type;
                t_frame = exp_frame;
                t_resp  = exp_resp;
                t_err   = exp_err;
            end else if (active) begin
                age = age + 1;
            end
            if (active && age > 0 && cmd_busy !== 1'b1) begin
                flag_mismatch("cmd_busy", 1, cmd_busy);
            end

            // Frame on the line: edge 2 after the request, 48 cycles long
            if (cmd_oe && !oe_q) begin
                if (!active || sent || age != 2) begin
                    flag_protocol("frame started at an unexpected cycle");
                end
                nbits = 0;
            end
            if (cmd_oe) begin
                bits  = {bits[FRAME_BITS-2:0], cmd_out};
                nbits = nbits + 1;
            end
            oe_fall = oe_q && !cmd_oe;
            if (oe_fall) begin
                if (nbits != FRAME_BITS) begin
                    flag_protocol($sformatf("frame lasted %0d cycles", nbits));
                end
                if (bits !== t_frame) begin
                    flag_mismatch("cmd_out frame", t_frame, bits);
                end
                sent = 1'b1;
            end
            if (cmd_done !== oe_fall) begin
                flag_mismatch("cmd_done", oe_fall, cmd_done);
            end
            if (oe_fall && active && t_type == RESP_NONE) begin
                active      = 1'b0;
                release_due = 1'b1;
            end

            if (resp_done) begin
                if (!(active && sent && t_type == RESP_48)) begin
                    flag_protocol("resp_done without a pending response");
                end else begin
                    if (resp_data !== t_resp) begin
                        flag_mismatch("resp_data", t_resp, resp_data);
                    end
                    if (resp_crc_err !== t_err) begin
                        flag_mismatch("resp_crc_err", t_err, resp_crc_err);
                    end
                    active      = 1'b0;
                    release_due = 1'b1;
                end
            end
            oe_q = cmd_oe;
        end
    end

endmodule

`default_nettype wire

//--- verif/sd_cmd_tb.sv
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_tb;
    import sd_cmd_pkg::*;

    localparam int    CYCLES_PER_PATTERN = 200;
    localparam string PATTERN_FILE       = "verif/sd_cmd_patterns.txt";

    logic        clk_fast;
    logic        init_resetPulse;
    logic        cmd_start;
    payload_t    cmd_payload;
    resp_type_t  cmd_resp_type;
    logic        cmd_in;
    logic        cmd_busy;
    logic        cmd_done;
    logic        cmd_out;
    logic        cmd_oe;
    logic        resp_done;
    frame_t      resp_data;
    logic        resp_crc_err;
    resp_type_t  exp_resp_type;
    frame_t      exp_frame;
    frame_t      exp_resp;
    logic        exp_err;
    int          card_delay;
    int          value_errors;
    int          protocol_errors;
    bit          patterns_loaded;

    payload_t    pat_payload[$];
    resp_type_t  pat_type[$];
    frame_t      pat_frame[$];
    frame_t      pat_resp[$];
    logic        pat_err[$];

    sd_cmd_top dut_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_start       (cmd_start),
        .cmd_payload     (cmd_payload),
        .cmd_resp_type   (cmd_resp_type),
        .cmd_in          (cmd_in),
        .cmd_busy        (cmd_busy),
        .cmd_done        (cmd_done),
        .cmd_out         (cmd_out),
        .cmd_oe          (cmd_oe),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err)
    );

    sd_cmd_checker chk_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_start       (cmd_start),
        .cmd_busy        (cmd_busy),
        .cmd_done        (cmd_done),
        .cmd_out         (cmd_out),
        .cmd_oe          (cmd_oe),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err),
        .exp_resp_type   (exp_resp_type),
        .exp_frame       (exp_frame),
        .exp_resp        (exp_resp),
        .exp_err         (exp_err),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors)
    );

    bind sd_cmd_top sd_cmd_sva sva_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_busy        (cmd_busy),
        .cmd_done        (cmd_done),
        .cmd_oe          (cmd_oe),
        .resp_done       (resp_done)
    );

    initial begin
        clk_fast = 1'b0;
        forever #4 clk_fast = ~clk_fast;
    end

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        payload_t    p;
        resp_type_t  t;
        frame_t      f;
        frame_t      r;
        logic        e;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Pattern file %s could not be opened", PATTERN_FILE);
            return;
        end
        while ($fgets(line, fd) > 0) begin
            // Comment and blank lines hold no transaction
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", p, t, f, r, e);
                if (n == 5) begin
                    pat_payload.push_back(p);
                    pat_type.push_back(t);
                    pat_frame.push_back(f);
                    pat_resp.push_back(r);
                    pat_err.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_transaction(input int i);
        int dup_at;
        dup_at     = 3 + ($urandom % 38);
        card_delay = 2 + ($urandom % 19);
        cmd_start     <= 1'b1;
        cmd_payload   <= pat_payload[i];
        cmd_resp_type <= pat_type[i];
        exp_resp_type <= pat_type[i];
        exp_frame     <= pat_frame[i];
        exp_resp      <= pat_resp[i];
        exp_err       <= pat_err[i];
        @(posedge clk_fast);
        cmd_start <= 1'b0;
        repeat (dup_at - 1) @(posedge clk_fast);
        // Second request lands while the first frame is still in flight
        cmd_start     <= 1'b1;
        cmd_payload   <= ~pat_payload[i];
        cmd_resp_type <= ~pat_type[i];
        @(posedge clk_fast);
        cmd_start <= 1'b0;
        if (pat_type[i] == RESP_48) begin
            do @(posedge clk_fast); while (!resp_done);
        end else begin
            do @(posedge clk_fast); while (!cmd_done);
            repeat (30) @(posedge clk_fast);
        end
        repeat (4) @(posedge clk_fast);
    endtask

    task automatic drive_card_response(input frame_t frame, input int delay);
        repeat (delay) @(posedge clk_fast);
        for (int b = FRAME_BITS - 1; b >= 0; b--) begin
            cmd_in <= frame[b];
            @(posedge clk_fast);
        end
        cmd_in <= 1'b1;
    endtask

    // ======================================================================
    // Card model, answers once the host releases the line
    // ======================================================================
    initial begin : card_model
        logic oe_q;
        oe_q = 1'b0;
        forever begin
            @(posedge clk_fast);
            if (oe_q && !cmd_oe && exp_resp_type == RESP_48) begin
                drive_card_response(exp_resp, card_delay);
            end
            oe_q = cmd_oe;
        end
    end

    initial begin : watchdog
        wait (patterns_loaded);
        repeat ((pat_payload.size() + 1) * CYCLES_PER_PATTERN) @(posedge clk_fast);
        $display("Watchdog expired, the DUT stopped completing transactions");
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        int sva_fails;
        void'($urandom(35845));
        init_resetPulse = 1'b1;
        cmd_start       = 1'b0;
        cmd_payload     = '0;
        cmd_resp_type   = RESP_NONE;
        cmd_in          = 1'b1;
        exp_resp_type   = RESP_NONE;
        exp_frame       = '0;
        exp_resp        = '0;
        exp_err         = 1'b0;
        card_delay      = 2;
        load_patterns();
        patterns_loaded = 1'b1;
        repeat (4) @(posedge clk_fast);
        init_resetPulse <= 1'b0;
        repeat (3) @(posedge clk_fast);
        foreach (pat_payload[i]) begin
            run_transaction(i);
        end
        repeat (4) @(posedge clk_fast);
        sva_fails = dut_i.sva_i.fail_cnt;
        $display("Error counts: value %0d, protocol %0d, assertion %0d over %0d patterns",
                 value_errors, protocol_errors, sva_fails, pat_payload.size());
        if (pat_payload.size() > 0 && value_errors + protocol_errors + sva_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/sd_cmd_patterns.txt
# payload     rtype  cmd_frame     card_resp     crc_err
# rtype 0 has no response, its card_resp column is unused
4000000000    0      400000000095  000000000000  0
48000001AA    1      48000001AA87  08000001AA13  0
7700000000    1      770000000065  370000012083  0
6940000000    1      694000000077  370000012081  1
7A00000000    0      7A00000000FD  000000000000  0
5100001000    1      510000100027  08000001AA12  1
4712340000    1      471234000059  070000070075  0
4C00000000    0      4C0000000061  000000000000  0
5000000200    1      500000020015  10000009000B  0
4D12340000    1      4D12340000D7  0700000700F5  1
4100000000    0      4100000000F9  000000000000  0

//--- verilog.f
src/sd_cmd_pkg.sv
src/sd_crc7.sv
src/sd_cmd_tx.sv
src/sd_resp_rx.sv
src/sd_cmd_ctrl.sv
src/sd_cmd_top.sv
verif/sd_cmd_sva.sv
verif/sd_cmd_checker.sv
verif/sd_cmd_tb.sv

//--- Bender.yml
package:
  name: sd_cmd

sources:
  - src/sd_cmd_pkg.sv
  - src/sd_crc7.sv
  - src/sd_cmd_tx.sv
  - src/sd_resp_rx.sv
  - src/sd_cmd_ctrl.sv
  - src/sd_cmd_top.sv
  - target: test
    files:
      - verif/sd_cmd_sva.sv
      - verif/sd_cmd_checker.sv
      - verif/sd_cmd_tb.sv
